/* hdl/fxpPkg.sv */
`default_nettype none

package fxpPkg;

    // Q7.8 signed fixed point
    localparam int FXP_INT_BITS = 7;
    localparam int FXP_FRAC_BITS = 8;
    localparam int FXP_WIDTH = 1 + FXP_INT_BITS + FXP_FRAC_BITS;

    // Lanes per input vector
    localparam int VEC_LEN = 8;

    // Adder layers between two tree registers
    localparam int ADDERS_PER_STAGE = 2;
    localparam int TREE_LAYERS = $clog2(VEC_LEN);
    localparam int TREE_LATENCY = (TREE_LAYERS + ADDERS_PER_STAGE - 1) / ADDERS_PER_STAGE;

    // Multiplier, tree, then bias stage
    localparam int PIPE_LATENCY = 1 + TREE_LATENCY + 1;

    typedef logic signed [FXP_WIDTH-1:0] fxpT;
    typedef logic signed [2*FXP_WIDTH-1:0] fxpProdT;
    typedef fxpT [VEC_LEN-1:0] fxpVecT;

    typedef logic [7:0] apbAddrT;
    typedef logic [31:0] apbDataT;

    // Register map, weight i sits at REG_WEIGHT0 + 4*i
    localparam apbAddrT REG_WEIGHT0 = 8'h00;
    localparam apbAddrT REG_BIAS = 8'h20;
    localparam apbAddrT REG_CTRL = 8'h24;
    localparam apbAddrT REG_OUTCNT = 8'h28;

endpackage

`default_nettype wire

/* hdl/neuronCfgIf.sv */
`timescale 1ns/1ns
`default_nettype none

interface neuronCfgIf import fxpPkg::*; ();

    // One weight per input lane
    fxpVecT weights;
    fxpT bias;
    logic reluEnable;

    // Register block owns all configuration
    modport regs (
        output weights,
        output bias,
        output reluEnable
    );

    modport mult (
        input weights
    );

    // Bias and clamp are applied after the tree
    modport out (
        input bias,
        input reluEnable
    );

endinterface

`default_nettype wire

/* hdl/neuronApbRegs.sv */
`timescale 1ns/1ns
`default_nettype none

module neuronApbRegs import fxpPkg::*; (
    input  logic    clk,
    input  logic    reset,
    input  apbAddrT paddr,
    input  logic    psel,
    input  logic    penable,
    input  logic    pwrite,
    input  apbDataT pwdata,
    output apbDataT prdata,
    output logic    pready,
    output logic    pslverr,
    neuronCfgIf.regs cfg,
    input  logic    outPulse
);

    localparam int IDX_BITS = $clog2(VEC_LEN);
    localparam apbAddrT WEIGHT_SPAN = apbAddrT'(4 * VEC_LEN);

    fxpVecT weights;
    fxpT bias;
    logic reluEnable;
    apbDataT outCount;

    logic access;
    apbAddrT weightOffset;
    logic [IDX_BITS-1:0] weightIdx;
    logic weightHit;
    logic isBias;
    logic isCtrl;
    logic isOutCnt;
    logic errAccess;
    logic writeEn;
    apbDataT readData;

    // Address decode
    assign access = psel & penable;
    assign weightOffset = paddr - REG_WEIGHT0;
    assign weightIdx = weightOffset[IDX_BITS+1:2];
    assign weightHit = (weightOffset < WEIGHT_SPAN) && (weightOffset[1:0] == 2'b00);
    assign isBias = (paddr == REG_BIAS);
    assign isCtrl = (paddr == REG_CTRL);
    assign isOutCnt = (paddr == REG_OUTCNT);

    // Unmapped address, or a write to the read-only counter
    assign errAccess = !(weightHit || isBias || isCtrl || isOutCnt) || (pwrite && isOutCnt);

    assign pready = 1'b1;
    assign pslverr = access && errAccess;
    assign writeEn = access && pwrite && !errAccess;

    always_ff @(posedge clk) begin
        if (reset) begin
            weights <= '0;
            bias <= '0;
            reluEnable <= 1'b0;
        end else if (writeEn) begin
            if (weightHit) begin
                weights[weightIdx] <= pwdata[FXP_WIDTH-1:0];
            end else if (isBias) begin
                bias <= pwdata[FXP_WIDTH-1:0];
            end else if (isCtrl) begin
                reluEnable <= pwdata[0];
            end
        end
    end

    // Counts produced outputs, wraps at 2^32
    always_ff @(posedge clk) begin
        if (reset) begin
            outCount <= '0;
        end else if (outPulse) begin
            outCount <= outCount + 1'b1;
        end
    end

    // Read mux, unmapped addresses read as zero
    always_comb begin
        readData = '0;
        if (weightHit) begin
            readData[FXP_WIDTH-1:0] = weights[weightIdx];
        end else if (isBias) begin
            readData[FXP_WIDTH-1:0] = bias;
        end else if (isCtrl) begin
            readData[0] = reluEnable;
        end else if (isOutCnt) begin
            readData = outCount;
        end
    end

    assign prdata = readData;

    assign cfg.weights = weights;
    assign cfg.bias = bias;
    assign cfg.reluEnable = reluEnable;

endmodule

`default_nettype wire

/* hdl/fxpMultArray.sv */
`timescale 1ns/1ns
`default_nettype none

module fxpMultArray import fxpPkg::*; (
    input  logic   clk,
    input  logic   reset,
    neuronCfgIf.mult cfg,
    input  logic   inValid,
    input  fxpVecT inVec,
    output logic   prodValid,
    output fxpVecT prodVec
);

    fxpVecT scaledVec;

    for (genvar i = 0; i < VEC_LEN; i++) begin : genLane
        fxpProdT product;
        fxpProdT scaled;

        // Full width product, both operands sign extended first
        assign product = fxpProdT'(inVec[i]) * fxpProdT'(cfg.weights[i]);

        // Drop the extra fraction bits, keep the low word
        assign scaled = product >>> FXP_FRAC_BITS;
        assign scaledVec[i] = scaled[FXP_WIDTH-1:0];
    end

    always_ff @(posedge clk) begin
        prodVec <= scaledVec;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            prodValid <= 1'b0;
        end else begin
            prodValid <= inValid;
        end
    end

endmodule

`default_nettype wire

/* hdl/fxpAdderTree.sv */
`timescale 1ns/1ns
`default_nettype none

module fxpAdderTree import fxpPkg::*; #(
    parameter int SIZE = VEC_LEN,
    parameter int ADDERS_PER_LAYER_GROUP = ADDERS_PER_STAGE
) (
    input  logic            clk,
    input  logic            reset,
    input  logic            inValid,
    input  fxpT [SIZE-1:0]  inVec,
    output logic            outValid,
    output fxpT             sum
);

    localparam int LAYERS = $clog2(SIZE);

    // A single input still gets one register
    localparam int STAGES = (LAYERS == 0) ? 1 :
        (LAYERS + ADDERS_PER_LAYER_GROUP - 1) / ADDERS_PER_LAYER_GROUP;

    // Number of values left after a given layer
    function automatic int nodeCount(input int layer);
        int n;
        n = SIZE;
        for (int i = 0; i < layer; i++) begin
            n = (n + 1) / 2;
        end
        return n;
    endfunction

    // Row 0 is the input, row l the output of adder layer l
    fxpT layerVal [0:LAYERS][0:SIZE-1];
    logic [STAGES-1:0] validPipe;

    for (genvar k = 0; k < SIZE; k++) begin : genInput
        assign layerVal[0][k] = inVec[k];
    end

    for (genvar l = 1; l <= LAYERS; l++) begin : genLayer
        localparam int PREV = nodeCount(l - 1);
        localparam int CUR = nodeCount(l);
        localparam bit REGISTERED = ((l % ADDERS_PER_LAYER_GROUP) == 0) || (l == LAYERS);

        for (genvar j = 0; j < SIZE; j++) begin : genNode
            if (j < CUR) begin : genActive
                fxpT nodeSum;

                // Pairs are added with wrap, an odd last element passes through
                if (2 * j + 1 < PREV) begin : genAdd
                    assign nodeSum = layerVal[l-1][2*j] + layerVal[l-1][2*j+1];
                end else begin : genPass
                    assign nodeSum = layerVal[l-1][2*j];
                end

                if (REGISTERED) begin : genReg
                    fxpT nodeReg;

                    always_ff @(posedge clk) begin
                        nodeReg <= nodeSum;
                    end

                    assign layerVal[l][j] = nodeReg;
                end else begin : genComb
                    assign layerVal[l][j] = nodeSum;
                end
            end else begin : genUnused
                assign layerVal[l][j] = '0;
            end
        end
    end

    if (LAYERS == 0) begin : genSingle
        fxpT singleReg;

        always_ff @(posedge clk) begin
            singleReg <= layerVal[0][0];
        end

        assign sum = singleReg;
    end else begin : genRoot
        assign sum = layerVal[LAYERS][0];
    end

    // Valid travels through as many registers as the data
    always_ff @(posedge clk) begin
        if (reset) begin
            validPipe <= '0;
        end else begin
            validPipe[0] <= inValid;
            for (int i = 1; i < STAGES; i++) begin
                validPipe[i] <= validPipe[i-1];
            end
        end
    end

    assign outValid = validPipe[STAGES-1];

endmodule

`default_nettype wire

/* hdl/neuronOutStage.sv */
`timescale 1ns/1ns
`default_nettype none

module neuronOutStage import fxpPkg::*; (
    input  logic clk,
    input  logic reset,
    neuronCfgIf.out cfg,
    input  logic sumValid,
    input  fxpT  sum,
    output logic outValid,
    output fxpT  outData
);

    fxpT biased;
    fxpT activated;

    // Wraps modulo 2^16
    assign biased = sum + cfg.bias;

    // ReLU looks only at the sign bit
    assign activated = (cfg.reluEnable && biased[FXP_WIDTH-1]) ? '0 : biased;

    // Output holds its last value between results
    always_ff @(posedge clk) begin
        if (sumValid) begin
            outData <= activated;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            outValid <= 1'b0;
        end else begin
            outValid <= sumValid;
        end
    end

endmodule

`default_nettype wire

/* hdl/fxpNeuron.sv */
`timescale 1ns/1ns
`default_nettype none

module fxpNeuron import fxpPkg::*; (
    input  logic    clk,
    input  logic    reset,

    // APB slave
    input  apbAddrT paddr,
    input  logic    psel,
    input  logic    penable,
    input  logic    pwrite,
    input  apbDataT pwdata,
    output apbDataT prdata,
    output logic    pready,
    output logic    pslverr,

    // Vector stream
    input  logic    inValid,
    input  fxpVecT  inVec,
    output logic    outValid,
    output fxpT     outData
);

    neuronCfgIf cfgIf ();

    logic prodValid;
    fxpVecT prodVec;
    logic sumValid;
    fxpT sum;

    // Each output also bumps the counter register
    neuronApbRegs u_regs (
        .clk      (clk),
        .reset    (reset),
        .paddr    (paddr),
        .psel     (psel),
        .penable  (penable),
        .pwrite   (pwrite),
        .pwdata   (pwdata),
        .prdata   (prdata),
        .pready   (pready),
        .pslverr  (pslverr),
        .cfg      (cfgIf.regs),
        .outPulse (outValid)
    );

    fxpMultArray u_multArray (
        .clk       (clk),
        .reset     (reset),
        .cfg       (cfgIf.mult),
        .inValid   (inValid),
        .inVec     (inVec),
        .prodValid (prodValid),
        .prodVec   (prodVec)
    );

    fxpAdderTree #(
        .SIZE                   (VEC_LEN),
        .ADDERS_PER_LAYER_GROUP (ADDERS_PER_STAGE)
    ) u_adderTree (
        .clk      (clk),
        .reset    (reset),
        .inValid  (prodValid),
        .inVec    (prodVec),
        .outValid (sumValid),
        .sum      (sum)
    );

    neuronOutStage u_outStage (
        .clk      (clk),
        .reset    (reset),
        .cfg      (cfgIf.out),
        .sumValid (sumValid),
        .sum      (sum),
        .outValid (outValid),
        .outData  (outData)
    );

endmodule

`default_nettype wire

/* bench/fxpNeuron_checker.sv */
`timescale 1ns/1ns
`default_nettype none

module fxpNeuron_checker import fxpPkg::*; (
    input logic clk,
    input logic reset,
    input logic psel,
    input logic penable,
    input logic pslverr,
    input logic inValid,
    input logic outValid,
    input fxpT  outData
);

    // Failure count, read by the testbench at the end
    int assertFails = 0;

    // Each accepted vector gives one result exactly PIPE_LATENCY cycles later
    assert property (@(posedge clk) disable iff (reset)
        inValid |-> ##PIPE_LATENCY outValid)
    else begin
        assertFails++;
        $error("No result %0d cycles after an accepted vector", PIPE_LATENCY);
    end

    assert property (@(posedge clk) disable iff (reset)
        outValid |-> $past(inValid, PIPE_LATENCY))
    else begin
        assertFails++;
        $error("Result without a vector %0d cycles earlier", PIPE_LATENCY);
    end

    assert property (@(posedge clk) disable iff (reset)
        outValid |-> !$isunknown(outData))
    else begin
        assertFails++;
        $error("outData has unknown bits while outValid is high");
    end

    // Errors only in the access phase
    assert property (@(posedge clk) pslverr |-> (psel && penable))
    else begin
        assertFails++;
        $error("pslverr high outside an APB access phase");
    end

    assert property (@(posedge clk) reset |=> !outValid)
    else begin
        assertFails++;
        $error("outValid high in the cycle after reset");
    end

endmodule

bind fxpNeuron fxpNeuron_checker u_checker (.*);

`default_nettype wire

/* bench/tbFxpNeuron.sv */
`timescale 1ns/1ns
`default_nettype none

module tbFxpNeuron import fxpPkg::*; ();

    localparam int RAND_VECTORS = 200;
    localparam int RELU_VECTORS = 40;
    localparam int GAP_VECTORS = 30;
    localparam int RESET_VECTORS = 6;
    localparam int TOTAL_VECTORS = RAND_VECTORS + RELU_VECTORS + GAP_VECTORS + RESET_VECTORS;

    logic clk, reset, psel, penable, pwrite, pready, pslverr;
    logic inValid, outValid;
    apbAddrT paddr;
    apbDataT pwdata, prdata;
    fxpVecT inVec;
    fxpT outData;

    integer seed = 32'h6a51_f2e5;
    int errors = 0;
    int sentCount = 0;
    int zeroCount = 0;
    int posCount = 0;
    string testName = "reset";
    fxpT expQ[$];

    // Configuration as software last wrote it
    fxpVecT curWeights;
    fxpT curBias;
    logic curRelu;

    fxpNeuron u_dut (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        #((TOTAL_VECTORS + 100) * 10 * 4);
        $display("Watchdog expired before the tests finished");
        $display("TEST FAILED");
        $finish;
    end

    // Q7.8 product keeps bits 23:8, every sum wraps at 16 bits
    function automatic fxpT neuronModel(input fxpVecT vec);
        logic signed [31:0] prod;
        logic [15:0] acc;
        acc = curBias;
        for (int i = 0; i < VEC_LEN; i++) begin
            prod = $signed(vec[i]) * $signed(curWeights[i]);
            acc = acc + prod[23:8];
        end
        if (curRelu && acc[15]) begin
            acc = '0;
        end
        return acc;
    endfunction

    function automatic fxpVecT randomVec();
        fxpVecT v;
        for (int i = 0; i < VEC_LEN; i++) begin
            v[i] = fxpT'($random(seed));
        end
        return v;
    endfunction

    // One APB transfer, then pslverr and read data are compared
    task automatic apbCheck(input logic write, input apbAddrT addr, input apbDataT data,
                            input logic expErr);
        int waited;
        waited = 0;
        @(posedge clk);
        #1;
        psel = 1'b1;
        penable = 1'b0;
        pwrite = write;
        paddr = addr;
        pwdata = write ? data : '0;
        @(posedge clk);
        #1;
        penable = 1'b1;
        @(negedge clk);
        while (!pready && waited < 16) begin
            @(negedge clk);
            waited++;
        end
        assert (pready) else begin
            errors++;
            $display("APB transfer to %h got no pready in test %s", addr, testName);
        end
        assert (pslverr === expErr && (write || prdata === data)) else begin
            errors++;
            $display("ERR %s addr %h expected %h/%b actual %h/%b", testName, addr,
                     data, expErr, prdata, pslverr);
        end
        @(posedge clk);
        #1;
        psel = 1'b0;
        penable = 1'b0;
    endtask

    // Upper data bits carry junk that the DUT must ignore
    task automatic configure(input fxpT bias, input logic relu);
        curWeights = randomVec();
        curBias = bias;
        curRelu = relu;
        for (int i = 0; i < VEC_LEN; i++) begin
            apbCheck(1'b1, REG_WEIGHT0 + apbAddrT'(4 * i),
                     {16'($random(seed)), curWeights[i]}, 1'b0);
        end
        apbCheck(1'b1, REG_BIAS, {16'hdead, bias}, 1'b0);
        apbCheck(1'b1, REG_CTRL, {31'h5a5a_5a5a, relu}, 1'b0);
    endtask

    task automatic checkConfig();
        for (int i = 0; i < VEC_LEN; i++) begin
            apbCheck(1'b0, REG_WEIGHT0 + apbAddrT'(4 * i), {16'h0, curWeights[i]}, 1'b0);
        end
        apbCheck(1'b0, REG_BIAS, {16'h0, curBias}, 1'b0);
        apbCheck(1'b0, REG_CTRL, {31'h0, curRelu}, 1'b0);
    endtask

    task automatic sendVector(input fxpVecT vec);
        @(posedge clk);
        #1;
        inValid = 1'b1;
        inVec = vec;
        expQ.push_back(neuronModel(vec));
        sentCount++;
    endtask

    // Data lanes keep toggling while inValid is low
    task automatic idle(input int cycles);
        repeat (cycles) begin
            @(posedge clk);
            #1;
            inValid = 1'b0;
            inVec = randomVec();
        end
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        idle(1);
        while (expQ.size() > 0 && waited < 2 * PIPE_LATENCY) begin
            @(posedge clk);
            waited++;
        end
        assert (expQ.size() == 0) else begin
            errors++;
            $display("%0d results never came out in test %s", expQ.size(), testName);
        end
        idle(PIPE_LATENCY + 2);
    endtask

    // Results are compared mid cycle, away from both edges
    initial begin : monitor
        fxpT expected;
        forever begin
            @(negedge clk);
            if (!reset && outValid) begin
                assert (expQ.size() > 0) else begin
                    errors++;
                    $display("Result came out with no vector in flight in test %s", testName);
                end
                if (expQ.size() > 0) begin
                    expected = expQ.pop_front();
                    assert (outData === expected) else begin
                        errors++;
                        $display("ERR %s expected %h actual %h", testName, expected, outData);
                    end
                    if (outData === '0) begin
                        zeroCount++;
                    end else if (!outData[FXP_WIDTH-1]) begin
                        posCount++;
                    end
                end
            end
        end
    end

    initial begin
        reset = 1'b1;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        paddr = '0;
        pwdata = '0;
        inValid = 1'b0;
        inVec = '0;
        curWeights = '0;
        curBias = '0;
        curRelu = 1'b0;
        repeat (2) @(posedge clk);
        #1;
        reset = 1'b0;

        testName = "regAccess";
        configure(fxpT'($random(seed)), 1'b1);
        checkConfig();

        // Misaligned weight address must not touch weight 1
        testName = "apbErrors";
        apbCheck(1'b1, 8'h2c, 32'hffff_ffff, 1'b1);
        apbCheck(1'b1, 8'h05, 32'hffff_ffff, 1'b1);
        apbCheck(1'b1, REG_OUTCNT, 32'h1234_5678, 1'b1);
        apbCheck(1'b0, 8'h2c, '0, 1'b1);
        apbCheck(1'b0, 8'h03, '0, 1'b1);
        apbCheck(1'b0, REG_OUTCNT, '0, 1'b0);
        checkConfig();

        testName = "randomStream";
        configure(fxpT'($random(seed)), 1'b0);
        repeat (RAND_VECTORS) sendVector(randomVec());
        drain();

        testName = "reluClamp";
        configure(fxpT'({1'b1, 15'($random(seed))}), 1'b1);
        zeroCount = 0;
        posCount = 0;
        repeat (RELU_VECTORS) sendVector(randomVec());
        drain();
        assert (zeroCount > 0 && posCount > 0) else begin
            errors++;
            $display("ReLU run did not produce both clamped and positive results");
        end

        testName = "validGaps";
        repeat (GAP_VECTORS) begin
            sendVector(randomVec());
            idle($random(seed) & 3);
        end
        drain();
        apbCheck(1'b0, REG_OUTCNT, apbDataT'(sentCount), 1'b0);

        // Reset lands while vectors are still in the pipeline
        testName = "midReset";
        repeat (RESET_VECTORS) sendVector(randomVec());
        @(posedge clk);
        #1;
        reset = 1'b1;
        inValid = 1'b0;
        expQ.delete();
        repeat (2) @(posedge clk);
        #1;
        reset = 1'b0;
        sentCount = 0;
        curWeights = '0;
        curBias = '0;
        curRelu = 1'b0;
        idle(PIPE_LATENCY + 2);
        apbCheck(1'b0, REG_OUTCNT, '0, 1'b0);
        checkConfig();

        $display("Finished with %0d check errors and %0d assertion failures",
                 errors, u_dut.u_checker.assertFails);
        if (errors == 0 && u_dut.u_checker.assertFails == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* flist.f */
hdl/fxpPkg.sv
hdl/neuronCfgIf.sv
hdl/neuronApbRegs.sv
hdl/fxpMultArray.sv
hdl/fxpAdderTree.sv
hdl/neuronOutStage.sv
hdl/fxpNeuron.sv
bench/fxpNeuron_checker.sv
bench/tbFxpNeuron.sv

/* Bender.yml */
package:
  name: fxp_neuron

sources:
  - hdl/fxpPkg.sv
  - hdl/neuronCfgIf.sv
  - hdl/neuronApbRegs.sv
  - hdl/fxpMultArray.sv
  - hdl/fxpAdderTree.sv
  - hdl/neuronOutStage.sv
  - hdl/fxpNeuron.sv
  - target: test
    files:
      - bench/fxpNeuron_checker.sv
      - bench/tbFxpNeuron.sv
